// File: dma_pkg.sv
// Shared definitions for the AXI4 burst DMA write master
// Holds the AXI field types, response codes, fixed burst attributes
// and the state encoding of the write control FSM
`default_nettype none

package dma_pkg;

   ////////////////////////////////////////
   // AXI field types
   ////////////////////////////////////////

   typedef logic [7:0] len_t;    // Burst length, beats minus one
   typedef logic [1:0] resp_t;   // Write response code
   typedef logic [1:0] burst_t;  // Burst type
   typedef logic [2:0] size_t;   // Bytes per beat as a log2 code
   typedef logic [3:0] cache_t;  // Memory type attributes
   typedef logic [2:0] prot_t;   // Protection attributes

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Response codes returned on the B channel
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_EXOKAY = 2'b01;  // Exclusive access success
   localparam resp_t RESP_SLVERR = 2'b10;  // Slave saw the access and rejected it
   localparam resp_t RESP_DECERR = 2'b11;  // No slave at this address

   localparam burst_t BURST_INCR = 2'b01;  // Address steps by the beat size

   // Bit 3 allocate, bit 2 other allocate, bit 1 modifiable, bit 0 bufferable
   localparam cache_t CACHE_WRITE_BACK = 4'b1111;

   // Bit 2 data access, bit 1 non-secure, bit 0 unprivileged
   localparam prot_t PROT_NON_SECURE = 3'b010;

   // Write control FSM
   typedef enum logic [1:0] {
      CTRL_IDLE  = 2'd0,  // Offering ready to the client
      CTRL_ADDR  = 2'd1,  // Holding awvalid until the slave takes the address
      CTRL_RESP  = 2'd2,  // Waiting with bready for the write response
      CTRL_ERROR = 2'd3   // Sticky until reset
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: dma_write_ctrl.sv
// Write control FSM of the DMA write master
// Takes a client command, issues it on the AXI write address channel
// and waits for the write response, which either re-arms the command
// port or parks the block in a sticky error state
`timescale 1ns/1ps
`default_nettype none

module dma_write_ctrl #(
   parameter int ADDR_WIDTH = 32
) (
   input  wire                    aclk,
   input  wire                    areset,
   // Client command port
   input  wire [ADDR_WIDTH-1:0]   write_addr,        // Start byte address of the burst
   input  dma_pkg::len_t          write_count,       // Beats minus one
   input  wire                    write_ctrl_valid,
   output logic                   write_ctrl_ready,
   output logic                   write_error,       // Set by a failed response
   // AXI write address channel
   output logic [ADDR_WIDTH-1:0]  m_axi_awaddr,
   output dma_pkg::len_t          m_axi_awlen,
   output logic                   m_axi_awvalid,
   input  wire                    m_axi_awready,
   // AXI write response channel
   input  dma_pkg::resp_t         m_axi_bresp,
   input  wire                    m_axi_bvalid,
   output logic                   m_axi_bready,
   // Link to the beat counter
   output logic                   beat_start,        // Pulses on the command handshake
   output dma_pkg::len_t          beat_len           // Length that goes with beat_start
);

   import dma_pkg::*;

   ctrl_state_t state;

   ////////////////////////////////////////
   // Command handshake
   ////////////////////////////////////////

   // Ready is only ever high in idle, so this is the whole accept condition
   assign beat_start = write_ctrl_valid & write_ctrl_ready;
   assign beat_len   = write_count;  // The counter latches it with the pulse

   ////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (areset) begin
         state            <= CTRL_IDLE;
         write_ctrl_ready <= 1'b0;  // Rises in the first cycle out of reset
         m_axi_awvalid    <= 1'b0;
         m_axi_bready     <= 1'b0;
         write_error      <= 1'b0;
      end else begin
         case (state)
            CTRL_IDLE: begin
               if (beat_start) begin
                  // Command taken, present it on AW from the next cycle
                  m_axi_awaddr     <= write_addr;
                  m_axi_awlen      <= write_count;
                  m_axi_awvalid    <= 1'b1;
                  write_ctrl_ready <= 1'b0;
                  state            <= CTRL_ADDR;
               end else begin
                  write_ctrl_ready <= 1'b1;  // Offer the port while nothing is in flight
               end
            end

            CTRL_ADDR: begin
               // Address and length stay put until the slave takes them
               if (m_axi_awready) begin
                  m_axi_awvalid <= 1'b0;
                  m_axi_bready  <= 1'b1;
                  state         <= CTRL_RESP;
               end
            end

            CTRL_RESP: begin
               if (m_axi_bvalid) begin
                  m_axi_bready <= 1'b0;  // One response per burst
                  case (m_axi_bresp)
                     RESP_OKAY, RESP_EXOKAY: begin
                        write_ctrl_ready <= 1'b1;  // Re-arm straight away
                        state            <= CTRL_IDLE;
                     end
                     default: begin
                        // SLVERR or DECERR, only a reset brings the block back
                        write_error <= 1'b1;
                        state       <= CTRL_ERROR;
                     end
                  endcase
               end
            end

            CTRL_ERROR: begin
               // Everything stays quiet and the stale address is wiped
               m_axi_awaddr     <= '0;
               m_axi_awlen      <= '0;
               m_axi_awvalid    <= 1'b0;
               m_axi_bready     <= 1'b0;
               write_ctrl_ready <= 1'b0;
               write_error      <= 1'b1;
            end

            default: begin
               state <= CTRL_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: dma_beat_counter.sv
// Data beat counter of the DMA write master
// Opens a burst when a command is accepted, passes client beats to the
// AXI write data channel, raises wlast on the final beat and closes the
// burst once that beat has been taken
`timescale 1ns/1ps
`default_nettype none

module dma_beat_counter #(
   parameter int DATA_WIDTH = 64
) (
   input  wire                    aclk,
   input  wire                    areset,
   // From the write control FSM
   input  wire                    beat_start,        // Command accepted this cycle
   input  dma_pkg::len_t          beat_len,          // Beats minus one
   // Client data port
   input  wire [DATA_WIDTH-1:0]   write_data,
   input  wire                    write_data_valid,
   output logic                   write_data_ready,
   // AXI write data channel
   output logic [DATA_WIDTH-1:0]  m_axi_wdata,
   output logic                   m_axi_wvalid,
   output logic                   m_axi_wlast,
   input  wire                    m_axi_wready
);

   import dma_pkg::*;

   logic burst_open;  // High while beats of the current burst may pass
   len_t len_q;       // Length of the open burst
   len_t beat_cnt;    // Beats already taken in this burst
   logic beat_fire;   // A data beat is handed over this cycle

   ////////////////////////////////////////
   // Data path gating
   ////////////////////////////////////////

   // Data goes straight through and only the handshake is gated
   assign m_axi_wdata      = write_data;
   assign m_axi_wvalid     = burst_open & write_data_valid;
   assign write_data_ready = burst_open & m_axi_wready;  // Stalls the client on low wready

   assign beat_fire = m_axi_wvalid & m_axi_wready;

   ////////////////////////////////////////
   // Beat counting and wlast
   ////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (areset) begin
         burst_open  <= 1'b0;
         beat_cnt    <= '0;
         m_axi_wlast <= 1'b0;
      end else if (beat_start) begin
         // New burst whose first beat may go out next cycle
         burst_open  <= 1'b1;
         beat_cnt    <= '0;
         m_axi_wlast <= (beat_len == '0);  // A single beat burst is last at once
      end else if (beat_fire) begin
         if (m_axi_wlast) begin
            // Final beat taken
            burst_open  <= 1'b0;
            m_axi_wlast <= 1'b0;
         end else begin
            beat_cnt    <= beat_cnt + 8'd1;
            // The beat after this one closes the burst when the count meets the length
            m_axi_wlast <= (beat_cnt + 8'd1 == len_q);
         end
      end
   end

   // Burst length taken together with the command pulse
   always_ff @(posedge aclk) begin
      if (beat_start) begin
         len_q <= beat_len;
      end
   end

endmodule

`default_nettype wire

// File: dma_write_master.sv
// AXI4 burst DMA write master, top level
// A client command becomes one INCR burst on AW, the client's words
// stream out on W, and the B response re-arms the command port or
// raises a sticky write error
`timescale 1ns/1ps
`default_nettype none

module dma_write_master #(
   parameter int ADDR_WIDTH = 32,
   parameter int DATA_WIDTH = 64  // Power of two, at least 8
) (
   input  wire                      aclk,
   input  wire                      areset,
   // Client command port
   input  wire [ADDR_WIDTH-1:0]     write_addr,        // Start byte address, beat aligned
   input  dma_pkg::len_t            write_count,       // Words to write minus one
   input  wire                      write_ctrl_valid,
   output logic                     write_ctrl_ready,
   // Client data port
   input  wire [DATA_WIDTH-1:0]     write_data,
   input  wire                      write_data_valid,
   output logic                     write_data_ready,
   output logic                     write_error,       // Sticky until reset
   // AXI write address channel
   output logic [ADDR_WIDTH-1:0]    m_axi_awaddr,
   output dma_pkg::len_t            m_axi_awlen,
   output dma_pkg::size_t           m_axi_awsize,
   output dma_pkg::burst_t          m_axi_awburst,
   output dma_pkg::cache_t          m_axi_awcache,
   output dma_pkg::prot_t           m_axi_awprot,
   output logic                     m_axi_awvalid,
   input  wire                      m_axi_awready,
   // AXI write data channel
   output logic [DATA_WIDTH-1:0]    m_axi_wdata,
   output logic [DATA_WIDTH/8-1:0]  m_axi_wstrb,
   output logic                     m_axi_wlast,
   output logic                     m_axi_wvalid,
   input  wire                      m_axi_wready,
   // AXI write response channel
   input  dma_pkg::resp_t           m_axi_bresp,
   input  wire                      m_axi_bvalid,
   output logic                     m_axi_bready
);

   import dma_pkg::*;

   logic beat_start;  // Command accepted, open a data burst
   len_t beat_len;    // Length of that burst

   ////////////////////////////////////////
   // Fixed burst attributes
   ////////////////////////////////////////

   assign m_axi_awsize  = size_t'($clog2(DATA_WIDTH / 8));  // Full bus width every beat
   assign m_axi_awburst = BURST_INCR;
   assign m_axi_awcache = CACHE_WRITE_BACK;
   assign m_axi_awprot  = PROT_NON_SECURE;
   assign m_axi_wstrb   = '1;  // Whole words only

   ////////////////////////////////////////
   // Address and response path
   ////////////////////////////////////////

   dma_write_ctrl #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) dma_write_ctrl_inst (
      .aclk             (aclk),
      .areset           (areset),
      .write_addr       (write_addr),
      .write_count      (write_count),
      .write_ctrl_valid (write_ctrl_valid),
      .write_ctrl_ready (write_ctrl_ready),
      .write_error      (write_error),
      .m_axi_awaddr     (m_axi_awaddr),
      .m_axi_awlen      (m_axi_awlen),
      .m_axi_awvalid    (m_axi_awvalid),
      .m_axi_awready    (m_axi_awready),
      .m_axi_bresp      (m_axi_bresp),
      .m_axi_bvalid     (m_axi_bvalid),
      .m_axi_bready     (m_axi_bready),
      .beat_start       (beat_start),
      .beat_len         (beat_len)
   );

   // Data path, may run ahead of the address handshake
   dma_beat_counter #(
      .DATA_WIDTH (DATA_WIDTH)
   ) dma_beat_counter_inst (
      .aclk             (aclk),
      .areset           (areset),
      .beat_start       (beat_start),
      .beat_len         (beat_len),
      .write_data       (write_data),
      .write_data_valid (write_data_valid),
      .write_data_ready (write_data_ready),
      .m_axi_wdata      (m_axi_wdata),
      .m_axi_wvalid     (m_axi_wvalid),
      .m_axi_wlast      (m_axi_wlast),
      .m_axi_wready     (m_axi_wready)
   );

endmodule

`default_nettype wire

// File: dma_write_checker.sv
// Protocol checker for the DMA write master
// Watches the AXI hold rules, how command ready relates to the sticky
// error, and that data beats only move while a command is in flight
`timescale 1ns/1ps
`default_nettype none

module dma_write_checker #(
   parameter int ADDR_WIDTH = 32
) (
   input  wire                    aclk,
   input  wire                    areset,
   input  wire                    write_ctrl_ready,
   input  wire                    write_error,
   input  wire [ADDR_WIDTH-1:0]   m_axi_awaddr,
   input  dma_pkg::len_t          m_axi_awlen,
   input  wire                    m_axi_awvalid,
   input  wire                    m_axi_awready,
   input  wire                    m_axi_wvalid,
   input  wire                    m_axi_wready,
   input  wire                    m_axi_wlast,
   input  wire                    m_axi_bready,
   input  dma_pkg::ctrl_state_t   ctrl_state         // State of the write control FSM
);

   import dma_pkg::*;

   ////////////////////////////////////////
   // AXI hold rules
   ////////////////////////////////////////

   // An address once offered stays until the slave takes it
   aw_hold: assert property (@(posedge aclk) disable iff (areset)
      m_axi_awvalid && !m_axi_awready |=>
         m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
      else $error("awvalid, awaddr or awlen changed before awready");

   w_hold: assert property (@(posedge aclk) disable iff (areset)
      m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wlast))
      else $error("wvalid or wlast changed before wready");  // Relies on a well behaved client

   ////////////////////////////////////////
   // Command port and error state
   ////////////////////////////////////////

   error_quiet: assert property (@(posedge aclk) disable iff (areset)
      write_error |-> !write_ctrl_ready && !m_axi_awvalid && !m_axi_bready)
      else $error("Control output active while write_error is set");

   // Only one burst may be in flight at a time
   ready_alone: assert property (@(posedge aclk) disable iff (areset)
      write_ctrl_ready |-> !m_axi_awvalid && !m_axi_bready)
      else $error("write_ctrl_ready high during an open address or response phase");

   ////////////////////////////////////////
   // Data beats against the FSM
   ////////////////////////////////////////

   // The data burst closes before the write response, so idle and error see no beats
   beat_in_burst: assert property (@(posedge aclk) disable iff (areset)
      (ctrl_state == CTRL_IDLE || ctrl_state == CTRL_ERROR) |-> !m_axi_wvalid)
      else $error("wvalid high while no command is in flight");

endmodule

`default_nettype wire

// File: tb_dma_write_master.sv
// Testbench for the AXI4 burst DMA write master
// Drives client commands and data words, models an AXI slave with random
// back-pressure and checks every burst against a reference function
`timescale 1ns/1ps
`default_nettype none

module tb_dma_write_master;

   import dma_pkg::*;

   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 64;
   localparam int WAIT_LIMIT = 2000;  // Cycles that any single wait may take

   logic                    aclk;
   logic                    areset;
   logic [ADDR_WIDTH-1:0]   write_addr;
   len_t                    write_count;
   logic                    write_ctrl_valid;
   logic                    write_ctrl_ready;
   logic [DATA_WIDTH-1:0]   write_data;
   logic                    write_data_valid;
   logic                    write_data_ready;
   logic                    write_error;
   logic [ADDR_WIDTH-1:0]   m_axi_awaddr;
   len_t                    m_axi_awlen;
   size_t                   m_axi_awsize;
   burst_t                  m_axi_awburst;
   cache_t                  m_axi_awcache;
   prot_t                   m_axi_awprot;
   logic                    m_axi_awvalid;
   logic                    m_axi_awready;
   logic [DATA_WIDTH-1:0]   m_axi_wdata;
   logic [DATA_WIDTH/8-1:0] m_axi_wstrb;
   logic                    m_axi_wlast;
   logic                    m_axi_wvalid;
   logic                    m_axi_wready;
   resp_t                   m_axi_bresp;
   logic                    m_axi_bvalid;
   logic                    m_axi_bready;

   integer seed = 81;

   // Command in progress as set by the test sequence before it is offered
   logic [ADDR_WIDTH-1:0]   cmd_addr;
   len_t                    cmd_count;
   resp_t                   resp_choice;  // What the slave answers on B

   // Handshakes seen by the slave model for the current burst
   logic [ADDR_WIDTH-1:0]   aw_addr_q[$];
   len_t                    aw_len_q[$];
   logic [DATA_WIDTH-1:0]   w_data_q[$];
   logic                    w_last_q[$];
   int                      aw_count;    // Address handshakes since reset
   int                      last_count;  // Final data beats since reset
   int                      b_count;     // Response handshakes since reset
   int                      b_issued;    // Responses raised by the slave
   logic                    in_flight;   // A command is accepted and unanswered
   logic                    rearm_due;   // Ready must be back this cycle

   dma_write_master dma_write_master_inst (
      .aclk             (aclk),
      .areset           (areset),
      .write_addr       (write_addr),
      .write_count      (write_count),
      .write_ctrl_valid (write_ctrl_valid),
      .write_ctrl_ready (write_ctrl_ready),
      .write_data       (write_data),
      .write_data_valid (write_data_valid),
      .write_data_ready (write_data_ready),
      .write_error      (write_error),
      .m_axi_awaddr     (m_axi_awaddr),
      .m_axi_awlen      (m_axi_awlen),
      .m_axi_awsize     (m_axi_awsize),
      .m_axi_awburst    (m_axi_awburst),
      .m_axi_awcache    (m_axi_awcache),
      .m_axi_awprot     (m_axi_awprot),
      .m_axi_awvalid    (m_axi_awvalid),
      .m_axi_awready    (m_axi_awready),
      .m_axi_wdata      (m_axi_wdata),
      .m_axi_wstrb      (m_axi_wstrb),
      .m_axi_wlast      (m_axi_wlast),
      .m_axi_wvalid     (m_axi_wvalid),
      .m_axi_wready     (m_axi_wready),
      .m_axi_bresp      (m_axi_bresp),
      .m_axi_bvalid     (m_axi_bvalid),
      .m_axi_bready     (m_axi_bready)
   );

   // Protocol assertions ride along inside the DUT scope
   bind dma_write_master dma_write_checker #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) dma_write_checker_inst (
      .aclk             (aclk),
      .areset           (areset),
      .write_ctrl_ready (write_ctrl_ready),
      .write_error      (write_error),
      .m_axi_awaddr     (m_axi_awaddr),
      .m_axi_awlen      (m_axi_awlen),
      .m_axi_awvalid    (m_axi_awvalid),
      .m_axi_awready    (m_axi_awready),
      .m_axi_wvalid     (m_axi_wvalid),
      .m_axi_wready     (m_axi_wready),
      .m_axi_wlast      (m_axi_wlast),
      .m_axi_bready     (m_axi_bready),
      .ctrl_state       (dma_write_ctrl_inst.state)
   );

   initial begin
      aclk = 1'b0;
      forever #50 aclk = ~aclk;  // 100 ns period
   end

   ////////////////////////////////////////
   // Reference and compare tasks
   ////////////////////////////////////////

   // Word number beat of a burst with the byte address of the beat in the upper half
   function automatic logic [DATA_WIDTH-1:0] expected_beat(input logic [31:0] addr,
                                                          input int beat);
      logic [31:0] beat_addr;
      logic [31:0] tag;
      beat_addr = addr + 32'(beat) * 32'd8;  // INCR steps by 8 bytes per beat
      tag       = ~addr ^ {16'h5a3c, 16'(beat)};
      return {beat_addr, tag};
   endfunction

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                             input logic [ADDR_WIDTH-1:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_len(input string name, input len_t got, input len_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s is %0d, expected %0d",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s is %b, expected %b",
                                     $time, name, got, exp));
      end
   endtask

   // Fixed AXI attribute fields zero extended to the strobe width
   task automatic check_field(input string name, input logic [DATA_WIDTH/8-1:0] got,
                              input logic [DATA_WIDTH/8-1:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                     $time, name, got, exp));
      end
   endtask

   // Checks a whole burst against its command when the write response arrives
   task automatic check_burst;
      int i;
      if (aw_addr_q.size() != 1) begin
         stop_with_failure("Burst did not see exactly one address handshake before B");
      end
      check_addr("m_axi_awaddr", aw_addr_q[0], cmd_addr);
      check_len("m_axi_awlen", aw_len_q[0], cmd_count);
      if (w_data_q.size() != int'(cmd_count) + 1) begin
         stop_with_failure($sformatf("Burst carried %0d data beats instead of %0d",
                                     w_data_q.size(), int'(cmd_count) + 1));
      end
      for (i = 0; i < w_data_q.size(); i++) begin
         check_data("m_axi_wdata", w_data_q[i], expected_beat(cmd_addr, i));
         check_flag("m_axi_wlast", w_last_q[i], i == int'(cmd_count));
      end
      aw_addr_q.delete();
      aw_len_q.delete();
      w_data_q.delete();
      w_last_q.delete();
   endtask

   ////////////////////////////////////////
   // AXI slave model
   ////////////////////////////////////////

   // Monitor and compare process sampling every channel on the rising edge
   initial begin
      aw_count   = 0;
      last_count = 0;
      b_count    = 0;
      in_flight  = 1'b0;
      rearm_due  = 1'b0;
      forever begin
         @(posedge aclk);
         if (areset) begin
            aw_addr_q.delete();
            aw_len_q.delete();
            w_data_q.delete();
            w_last_q.delete();
            aw_count   = 0;
            last_count = 0;
            b_count    = 0;
            in_flight  = 1'b0;
            rearm_due  = 1'b0;
         end else begin
            if (rearm_due) check_flag("write_ctrl_ready", write_ctrl_ready, 1'b1);
            rearm_due = 1'b0;
            if (in_flight) check_flag("write_ctrl_ready", write_ctrl_ready, 1'b0);
            if (!m_axi_wready) check_flag("write_data_ready", write_data_ready, 1'b0);
            if (m_axi_awvalid && m_axi_awready) begin
               aw_addr_q.push_back(m_axi_awaddr);
               aw_len_q.push_back(m_axi_awlen);
               check_field("m_axi_awsize", 8'(m_axi_awsize), 8'd3);  // 8 bytes a beat
               check_field("m_axi_awburst", 8'(m_axi_awburst), 8'(BURST_INCR));
               check_field("m_axi_awcache", 8'(m_axi_awcache), 8'(CACHE_WRITE_BACK));
               check_field("m_axi_awprot", 8'(m_axi_awprot), 8'(PROT_NON_SECURE));
               aw_count++;
            end
            if (m_axi_wvalid && m_axi_wready) begin
               w_data_q.push_back(m_axi_wdata);
               w_last_q.push_back(m_axi_wlast);
               check_field("m_axi_wstrb", m_axi_wstrb, 8'hff);
               if (m_axi_wlast) last_count++;
            end
            if (m_axi_bvalid && m_axi_bready) begin
               check_burst();
               b_count++;
               in_flight = 1'b0;
               rearm_due = (m_axi_bresp == RESP_OKAY) || (m_axi_bresp == RESP_EXOKAY);
            end
            if (write_ctrl_valid && write_ctrl_ready) in_flight = 1'b1;
         end
      end
   end

   // Ready and response driver that takes reset from the rising edge
   initial begin
      logic reset_seen;
      m_axi_awready = 1'b0;
      m_axi_wready  = 1'b0;
      m_axi_bvalid  = 1'b0;
      m_axi_bresp   = RESP_OKAY;
      b_issued      = 0;
      forever begin
         @(posedge aclk);
         reset_seen = areset;
         @(negedge aclk);
         if (reset_seen) begin
            m_axi_awready = 1'b0;
            m_axi_wready  = 1'b0;
            m_axi_bvalid  = 1'b0;
            b_issued      = 0;
         end else begin
            m_axi_awready = ($random(seed) % 3) != 0;
            m_axi_wready  = ($random(seed) % 3) != 0;
            if (m_axi_bvalid && b_count == b_issued) begin
               m_axi_bvalid = 1'b0;  // Taken on the last edge
            end else if (!m_axi_bvalid && aw_count > b_issued && last_count > b_issued
                         && ($random(seed) % 3) == 0) begin
               // B only after both the address and the final beat
               m_axi_bvalid = 1'b1;
               m_axi_bresp  = resp_choice;
               b_issued++;
            end
         end
      end
   end

   ////////////////////////////////////////
   // Client drivers
   ////////////////////////////////////////

   task automatic apply_reset;
      @(negedge aclk);
      areset = 1'b1;
      repeat (2) @(negedge aclk);
      areset = 1'b0;
      @(posedge aclk);
      // Everything is quiet in the first cycle out of reset
      check_flag("write_ctrl_ready", write_ctrl_ready, 1'b0);
      check_flag("m_axi_awvalid", m_axi_awvalid, 1'b0);
      check_flag("m_axi_wvalid", m_axi_wvalid, 1'b0);
      check_flag("m_axi_wlast", m_axi_wlast, 1'b0);
      check_flag("m_axi_bready", m_axi_bready, 1'b0);
      check_flag("write_data_ready", write_data_ready, 1'b0);
      check_flag("write_error", write_error, 1'b0);
   endtask

   task automatic send_command(input logic [ADDR_WIDTH-1:0] addr, input len_t count);
      int cycles;
      @(negedge aclk);
      write_addr       = addr;
      write_count      = count;
      write_ctrl_valid = 1'b1;
      cycles           = 0;
      do begin
         @(posedge aclk);
         cycles++;
         if (cycles > WAIT_LIMIT) stop_with_failure("Timed out waiting for write_ctrl_ready");
      end while (!write_ctrl_ready);
      @(negedge aclk);
      write_ctrl_valid = 1'b0;
   endtask

   task automatic send_data(input logic [ADDR_WIDTH-1:0] addr, input len_t count);
      int beat;
      int gap;
      int cycles;
      for (beat = 0; beat <= int'(count); beat++) begin
         @(negedge aclk);
         write_data_valid = 1'b0;
         gap = {$random(seed)} % 4;  // Idle cycles before this word
         repeat (gap) @(negedge aclk);
         write_data       = expected_beat(addr, beat);
         write_data_valid = 1'b1;
         cycles           = 0;
         do begin
            @(posedge aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_with_failure("Timed out waiting for write_data_ready");
         end while (!write_data_ready);
      end
      @(negedge aclk);
      write_data_valid = 1'b0;
   endtask

   // One command with its data that returns once the response was taken
   task automatic run_burst(input logic [ADDR_WIDTH-1:0] addr, input len_t count);
      int start_b;
      int cycles;
      start_b   = b_count;
      cmd_addr  = addr;
      cmd_count = count;
      fork
         send_command(addr, count);
         send_data(addr, count);
      join
      cycles = 0;
      while (b_count == start_b) begin
         @(negedge aclk);
         cycles++;
         if (cycles > WAIT_LIMIT) stop_with_failure("Timed out waiting for the write response");
      end
   endtask

   task automatic run_error_case(input resp_t resp);
      int i;
      resp_choice = resp;
      run_burst({$random(seed)} & 32'hffff_fff8, len_t'({$random(seed)} % 16));
      @(posedge aclk);
      check_flag("write_error", write_error, 1'b1);  // Up the cycle after B
      // A pending command must be ignored while the error holds
      @(negedge aclk);
      write_addr       = {$random(seed)} & 32'hffff_fff8;
      write_count      = 8'd3;
      write_ctrl_valid = 1'b1;
      for (i = 0; i < 24; i++) begin
         @(posedge aclk);
         check_flag("write_error", write_error, 1'b1);
         check_flag("write_ctrl_ready", write_ctrl_ready, 1'b0);
         check_flag("m_axi_awvalid", m_axi_awvalid, 1'b0);
      end
      @(negedge aclk);
      write_ctrl_valid = 1'b0;
      apply_reset();
      resp_choice = RESP_OKAY;
      run_burst({$random(seed)} & 32'hffff_fff8, len_t'({$random(seed)} % 16));
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [ADDR_WIDTH-1:0] addr;
      len_t                  count;
      int                    n;
      areset           = 1'b1;
      write_addr       = '0;
      write_count      = '0;
      write_ctrl_valid = 1'b0;
      write_data       = '0;
      write_data_valid = 1'b0;
      cmd_addr         = '0;
      cmd_count        = '0;
      resp_choice      = RESP_OKAY;
      apply_reset();
      for (n = 0; n < 40; n++) begin
         addr        = {$random(seed)} & 32'hffff_fff8;  // Beat aligned
         count       = (n == 0) ? 8'd0 : len_t'({$random(seed)} % 16);
         resp_choice = ($random(seed) % 2 == 0) ? RESP_OKAY : RESP_EXOKAY;
         run_burst(addr, count);
      end
      run_error_case(RESP_SLVERR);
      run_error_case(RESP_DECERR);
      $display("All tests passed");
      $finish;
   end

   // Last line of defence against a stuck run
   initial begin
      repeat (100000) @(posedge aclk);
      stop_with_failure("Simulation ran past its overall cycle limit");
   end

endmodule

`default_nettype wire

// File: list.f
dma_pkg.sv
dma_write_ctrl.sv
dma_beat_counter.sv
dma_write_master.sv
dma_write_checker.sv
tb_dma_write_master.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
# The exit status is nonzero when the build or any check fails

cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tb_dma_write_master -f list.f -o tb_sim \
   && ./obj_dir/tb_sim \
   || exit 1
